/* wallet_game_consts.svh */
`ifndef WALLET_GAME_CONSTS_SVH
`define WALLET_GAME_CONSTS_SVH

// Data path widths
`define WG_AMOUNT_W 16
`define WG_KEY_W 8
`define WG_DATA_W `WG_AMOUNT_W

// Player count, fixed by the two-player ledger
`define WG_PLAYERS 2

// Starting balances written by the init sequence
`define WG_INIT_BAL0 1000
`define WG_INIT_BAL1 500

// Player PINs
`define WG_PIN0 8'h3A
`define WG_PIN1 8'hC5

// Cycles spent in CLEAR before returning to IDLE
`define WG_CLEAR_CYCLES 4

`endif

/* wallet_game_pkg.sv */
`include "wallet_game_consts.svh"

package wallet_game_pkg;

    typedef enum logic [3:0] {
        STARTUP,
        INIT,
        IDLE,
        LOAD_PLAYER,
        WAIT1,
        LOAD_AMOUNT,
        WAIT2,
        LOAD_KEY,
        WAIT3,
        TRANSFER,
        CLEAR
    } game_state_t;

    // Entered by the operator one field per load press
    typedef struct packed {
        logic                    player;
        logic [`WG_AMOUNT_W-1:0] amount;
        logic [`WG_KEY_W-1:0]    key;
    } command_t;

    typedef enum logic [1:0] {
        OK,
        BAD_KEY,
        SHORT_FUNDS
    } outcome_t;

    typedef struct packed {
        outcome_t                status;
        logic                    player;
        logic [`WG_AMOUNT_W-1:0] balance0;  // Balances after the transfer
        logic [`WG_AMOUNT_W-1:0] balance1;
    } result_t;

endpackage

/* command_capture.sv */
`include "wallet_game_consts.svh"

module command_capture
    import wallet_game_pkg::*;
(
    input  logic                  clock,
    input  logic                  global_reset,
    input  logic [`WG_DATA_W-1:0] data,
    input  logic                  load_player,
    input  logic                  load_amount,
    input  logic                  load_key,
    input  logic                  clear_command,
    output command_t              command
);

    // Each strobe follows the switches while held, last value wins
    always_ff @(posedge clock) begin
        if (global_reset || clear_command) begin
            command <= '0;
        end else begin
            if (load_player) begin
                command.player <= data[0];
            end
            if (load_amount) begin
                command.amount <= data;
            end
            if (load_key) begin
                command.key <= data[`WG_KEY_W-1:0];
            end
        end
    end

    // Strobes come from separate FSM states
    one_load_strobe: assert property (
        @(posedge clock) disable iff (global_reset)
        $onehot0({load_player, load_amount, load_key})
    );

endmodule

/* main_control.sv */
`include "wallet_game_consts.svh"

module main_control
    import wallet_game_pkg::*;
(
    input  logic        clock,
    input  logic        global_reset,
    input  logic        start_signal,
    input  logic        load_signal,
    input  logic        abort,
    input  logic        init_done,
    input  logic        transfer_done,
    output logic        load_player,
    output logic        load_amount,
    output logic        load_key,
    output logic        clear_command,
    output logic        init_ledger,
    output logic        start_transfer,
    output game_state_t state
);

    localparam int CLEAR_W = $clog2(`WG_CLEAR_CYCLES + 1);

    game_state_t        next_state;
    logic [CLEAR_W-1:0] clear_count;

    always_comb begin
        case (state)
            STARTUP:     next_state = start_signal ? INIT : STARTUP;
            INIT:        next_state = init_done ? IDLE : INIT;
            IDLE:        next_state = load_signal ? LOAD_PLAYER : IDLE;
            LOAD_PLAYER: next_state = load_signal ? LOAD_PLAYER : WAIT1;
            WAIT1:       next_state = load_signal ? LOAD_AMOUNT : WAIT1;
            LOAD_AMOUNT: next_state = load_signal ? LOAD_AMOUNT : WAIT2;
            WAIT2:       next_state = load_signal ? LOAD_KEY : WAIT2;
            LOAD_KEY:    next_state = load_signal ? LOAD_KEY : WAIT3;
            WAIT3:       next_state = start_signal ? TRANSFER : WAIT3;
            TRANSFER:    next_state = transfer_done ? CLEAR : TRANSFER;
            CLEAR: begin
                if (clear_count == CLEAR_W'(`WG_CLEAR_CYCLES - 1)) begin
                    next_state = IDLE;
                end else begin
                    next_state = CLEAR;
                end
            end
            default:     next_state = STARTUP;
        endcase
        // Abort only once the ledger holds valid balances
        if (abort && state != STARTUP && state != INIT) begin
            next_state = CLEAR;
        end
    end

    always_ff @(posedge clock) begin
        if (global_reset) begin
            state <= STARTUP;
        end else begin
            state <= next_state;
        end
    end

    // Restarts from zero while abort is held in CLEAR
    always_ff @(posedge clock) begin
        if (global_reset) begin
            clear_count <= '0;
        end else if (state == CLEAR && next_state == CLEAR && !abort) begin
            clear_count <= clear_count + 1'b1;
        end else begin
            clear_count <= '0;
        end
    end

    // Moore outputs
    always_comb begin
        load_player    = 1'b0;
        load_amount    = 1'b0;
        load_key       = 1'b0;
        clear_command  = 1'b0;
        init_ledger    = 1'b0;
        start_transfer = 1'b0;
        case (state)
            INIT:        init_ledger = 1'b1;
            LOAD_PLAYER: load_player = 1'b1;
            LOAD_AMOUNT: load_amount = 1'b1;
            LOAD_KEY:    load_key = 1'b1;
            TRANSFER:    start_transfer = 1'b1;
            CLEAR:       clear_command = 1'b1;
            default:     ;
        endcase
    end

    // Without abort the clear phase lasts exactly WG_CLEAR_CYCLES cycles
    clear_phase_length: assert property (
        @(posedge clock) disable iff (global_reset || abort)
        $rose(state == CLEAR) |-> (state == CLEAR) [*`WG_CLEAR_CYCLES] ##1 (state == IDLE)
    );

    // Ledger finishes a transfer only while one is running or being aborted
    done_in_transfer: assert property (
        @(posedge clock) disable iff (global_reset)
        transfer_done |-> state inside {TRANSFER, CLEAR}
    );

endmodule

/* ledger.sv */
`include "wallet_game_consts.svh"

module ledger
    import wallet_game_pkg::*;
(
    input  logic                    clock,
    input  logic                    global_reset,
    input  logic                    init_ledger,
    input  logic                    start_transfer,
    input  command_t                command,
    output logic                    init_done,
    output logic                    transfer_done,
    output outcome_t                outcome,
    output logic [`WG_AMOUNT_W-1:0] balance0,
    output logic [`WG_AMOUNT_W-1:0] balance1
);

    logic [1:0]              init_step;
    logic                    initialized;
    logic [`WG_KEY_W-1:0]    pin0;
    logic [`WG_KEY_W-1:0]    pin1;
    logic                    start_q;
    logic                    start_pulse;
    logic [`WG_AMOUNT_W-1:0] payer_balance;
    logic [`WG_KEY_W-1:0]    payer_pin;
    outcome_t                check;
    logic                    s1_valid;
    outcome_t                s1_outcome;
    logic                    s1_player;
    logic [`WG_AMOUNT_W-1:0] s1_amount;
    logic [`WG_AMOUNT_W:0]   balance_sum;

    // Player 0 on step 0, player 1 on step 1, done on step 2
    assign init_done   = init_ledger && (init_step == 2'd2);
    assign start_pulse = start_transfer && !start_q;  // One transfer per TRANSFER visit
    assign balance_sum = balance0 + balance1;

    always_ff @(posedge clock) begin
        if (global_reset) begin
            init_step     <= '0;
            initialized   <= 1'b0;
            start_q       <= 1'b0;
            s1_valid      <= 1'b0;
            transfer_done <= 1'b0;
        end else begin
            if (!init_ledger) begin
                init_step <= '0;
            end else if (init_step != 2'd2) begin
                init_step <= init_step + 1'b1;
            end
            if (init_done) begin
                initialized <= 1'b1;
            end
            start_q       <= start_transfer;
            s1_valid      <= start_pulse;
            transfer_done <= s1_valid;
        end
    end

    // Checks in priority order, key first
    always_comb begin
        payer_balance = command.player ? balance1 : balance0;
        payer_pin     = command.player ? pin1 : pin0;
        if (command.key != payer_pin) begin
            check = BAD_KEY;
        end else if (command.amount > payer_balance) begin
            check = SHORT_FUNDS;
        end else begin
            check = OK;
        end
    end

    always_ff @(posedge clock) begin
        if (start_pulse) begin
            s1_outcome <= check;
            s1_player  <= command.player;
            s1_amount  <= command.amount;
        end
        if (s1_valid) begin
            outcome <= s1_outcome;
        end
    end

    always_ff @(posedge clock) begin
        if (init_ledger && init_step == 2'd0) begin
            balance0 <= `WG_AMOUNT_W'(`WG_INIT_BAL0);
            pin0     <= `WG_PIN0;
        end else if (init_ledger && init_step == 2'd1) begin
            balance1 <= `WG_AMOUNT_W'(`WG_INIT_BAL1);
            pin1     <= `WG_PIN1;
        end else if (s1_valid && s1_outcome == OK) begin
            if (s1_player) begin
                balance1 <= balance1 - s1_amount;
                balance0 <= balance0 + s1_amount;
            end else begin
                balance0 <= balance0 - s1_amount;
                balance1 <= balance1 + s1_amount;
            end
        end
    end

    // Money only moves between the two players
    sum_conserved: assert property (
        @(posedge clock) disable iff (global_reset)
        initialized |=> $stable(balance_sum)
    );

endmodule

/* result_reporter.sv */
`include "wallet_game_consts.svh"

module result_reporter
    import wallet_game_pkg::*;
(
    input  logic                    clock,
    input  logic                    global_reset,
    input  logic                    transfer_done,
    input  outcome_t                outcome,
    input  logic                    player,
    input  logic [`WG_AMOUNT_W-1:0] balance0,
    input  logic [`WG_AMOUNT_W-1:0] balance1,
    output result_t                 result,
    output logic                    result_valid,
    output logic [7:0]              transfer_count
);

    // Held until the next transfer finishes
    always_ff @(posedge clock) begin
        if (transfer_done) begin
            result.status   <= outcome;
            result.player   <= player;
            result.balance0 <= balance0;
            result.balance1 <= balance1;
        end
    end

    always_ff @(posedge clock) begin
        if (global_reset) begin
            result_valid   <= 1'b0;
            transfer_count <= '0;
        end else begin
            result_valid <= transfer_done;  // Single-cycle pulse
            if (transfer_done && outcome == OK) begin
                transfer_count <= transfer_count + 1'b1;
            end
        end
    end

endmodule

/* wallet_game_top.sv */
`include "wallet_game_consts.svh"

module wallet_game_top
    import wallet_game_pkg::*;
(
    input  logic                  clock,
    input  logic                  global_reset,
    input  logic                  start_signal,
    input  logic                  load_signal,
    input  logic                  abort,
    input  logic [`WG_DATA_W-1:0] data,
    output result_t               result,
    output logic                  result_valid,
    output logic [7:0]            transfer_count,
    output game_state_t           state
);

    command_t                command;
    logic                    load_player;
    logic                    load_amount;
    logic                    load_key;
    logic                    clear_command;
    logic                    init_ledger;
    logic                    init_done;
    logic                    start_transfer;
    logic                    transfer_done;
    outcome_t                outcome;
    logic [`WG_AMOUNT_W-1:0] balance0;
    logic [`WG_AMOUNT_W-1:0] balance1;

    command_capture u_capture (
        .clock         (clock),
        .global_reset  (global_reset),
        .data          (data),
        .load_player   (load_player),
        .load_amount   (load_amount),
        .load_key      (load_key),
        .clear_command (clear_command),
        .command       (command)
    );

    main_control u_control (
        .clock          (clock),
        .global_reset   (global_reset),
        .start_signal   (start_signal),
        .load_signal    (load_signal),
        .abort          (abort),
        .init_done      (init_done),
        .transfer_done  (transfer_done),
        .load_player    (load_player),
        .load_amount    (load_amount),
        .load_key       (load_key),
        .clear_command  (clear_command),
        .init_ledger    (init_ledger),
        .start_transfer (start_transfer),
        .state          (state)
    );

    ledger u_ledger (
        .clock          (clock),
        .global_reset   (global_reset),
        .init_ledger    (init_ledger),
        .start_transfer (start_transfer),
        .command        (command),
        .init_done      (init_done),
        .transfer_done  (transfer_done),
        .outcome        (outcome),
        .balance0       (balance0),
        .balance1       (balance1)
    );

    // Player is still held in the command register when the record is taken
    result_reporter u_reporter (
        .clock          (clock),
        .global_reset   (global_reset),
        .transfer_done  (transfer_done),
        .outcome        (outcome),
        .player         (command.player),
        .balance0       (balance0),
        .balance1       (balance1),
        .result         (result),
        .result_valid   (result_valid),
        .transfer_count (transfer_count)
    );

endmodule

/* tb_wallet_game.sv */
`include "wallet_game_consts.svh"

module tb_wallet_game
    import wallet_game_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 200;

    logic                  clock;
    logic                  global_reset;
    logic                  start_signal;
    logic                  load_signal;
    logic                  abort;
    logic [`WG_DATA_W-1:0] data;
    result_t               result;
    logic                  result_valid;
    logic [7:0]            transfer_count;
    game_state_t           state;

    int value_errors = 0;
    int timeout_errors = 0;
    int other_errors = 0;
    int model_bal0 = `WG_INIT_BAL0;
    int model_bal1 = `WG_INIT_BAL1;
    int ok_count = 0;
    int valid_pulses = 0;
    int expected_pulses = 0;

    wallet_game_top uut (
        .clock          (clock),
        .global_reset   (global_reset),
        .start_signal   (start_signal),
        .load_signal    (load_signal),
        .abort          (abort),
        .data           (data),
        .result         (result),
        .result_valid   (result_valid),
        .transfer_count (transfer_count),
        .state          (state)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Sees the value of the cycle before each edge
    always @(posedge clock) begin
        if (result_valid) begin
            valid_pulses++;
        end
    end

    task automatic step();
        @(posedge clock);
        #1;
    endtask

    task automatic finish_run();
        $display("Errors: %0d value, %0d timeout, %0d other",
                 value_errors, timeout_errors, other_errors);
        if (value_errors + timeout_errors + other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    task automatic check_result(input result_t got, input result_t exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %s player %0d balances %0d/%0d", $time, what,
                     got.status.name(), got.player, got.balance0, got.balance1);
            $display("    expected %s player %0d balances %0d/%0d",
                     exp.status.name(), exp.player, exp.balance0, exp.balance1);
            value_errors++;
        end
    endtask

    task automatic check_state(input game_state_t got, input game_state_t exp,
                               input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
            value_errors++;
        end
    endtask

    task automatic check_count(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_number(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic wait_for_state(input game_state_t target, input string what,
                                  output int cycles);
        cycles = 0;
        while (state != target && cycles < TIMEOUT) begin
            step();
            cycles++;
        end
        if (state != target) begin
            $display("Timeout: state never reached %s within %0d cycles", what, TIMEOUT);
            timeout_errors++;
            finish_run();
        end
    endtask

    task automatic wait_for_valid(output int cycles);
        cycles = 0;
        while (!result_valid && cycles < TIMEOUT) begin
            step();
            cycles++;
        end
        if (!result_valid) begin
            $display("Timeout: result_valid did not rise within %0d cycles", TIMEOUT);
            timeout_errors++;
            finish_run();
        end
    endtask

    // Button held a random 1 to 4 cycles, switches left as they are after release
    task automatic press_load(input logic [`WG_DATA_W-1:0] value, input game_state_t wait_state,
                              input string what);
        int hold;
        int cycles;
        hold = 1 + ($urandom % 4);
        data = value;
        load_signal = 1'b1;
        repeat (hold) step();
        load_signal = 1'b0;
        wait_for_state(wait_state, what, cycles);
    endtask

    task automatic run_transfer(input int player, input int amount, input logic [7:0] key,
                                input outcome_t file_status, input int file_bal0,
                                input int file_bal1, input int line_no);
        result_t exp;
        int      payer;
        int      pin;
        int      cycles;
        payer = player ? model_bal1 : model_bal0;
        pin   = player ? `WG_PIN1 : `WG_PIN0;
        if (key != pin) begin
            exp.status = BAD_KEY;
        end else if (amount > payer) begin
            exp.status = SHORT_FUNDS;
        end else begin
            exp.status = OK;
            ok_count++;
            if (player != 0) begin
                model_bal1 -= amount;
                model_bal0 += amount;
            end else begin
                model_bal0 -= amount;
                model_bal1 += amount;
            end
        end
        exp.player   = player[0];
        exp.balance0 = `WG_AMOUNT_W'(model_bal0);
        exp.balance1 = `WG_AMOUNT_W'(model_bal1);
        if (exp.status != file_status || model_bal0 != file_bal0 || model_bal1 != file_bal1) begin
            $display("Cases file line %0d disagrees with the balance model", line_no);
            other_errors++;
        end
        press_load(`WG_DATA_W'(player), WAIT1, "WAIT1 after the player press");
        press_load(`WG_DATA_W'(amount), WAIT2, "WAIT2 after the amount press");
        press_load(`WG_DATA_W'(key), WAIT3, "WAIT3 after the key press");
        start_signal = 1'b1;
        wait_for_state(TRANSFER, "TRANSFER after the start press", cycles);
        start_signal = 1'b0;
        expected_pulses++;
        wait_for_valid(cycles);
        check_number(cycles, 3, "result_valid latency from TRANSFER");
        check_result(result, exp, $sformatf("case on line %0d", line_no));
        check_state(state, CLEAR, "state with result_valid");
        step();
        check_number(result_valid, 0, "result_valid one cycle later");
        wait_for_state(IDLE, "IDLE after the clear phase", cycles);
        check_number(cycles + 1, `WG_CLEAR_CYCLES, "cycles spent in CLEAR");
    endtask

    // Abort once the amount is in, so no transfer may follow
    task automatic run_abort(input int player, input int amount);
        int cycles;
        press_load(`WG_DATA_W'(player), WAIT1, "WAIT1 after the player press");
        press_load(`WG_DATA_W'(amount), WAIT2, "WAIT2 after the amount press");
        abort = 1'b1;
        step();
        abort = 1'b0;
        check_state(state, CLEAR, "state after abort in WAIT2");
        wait_for_state(IDLE, "IDLE after the abort", cycles);
        check_number(valid_pulses, expected_pulses, "result_valid pulses after abort");
    endtask

    initial begin
        int         fd;
        int         line_no;
        int         op;
        int         player;
        int         amount;
        logic [7:0] key;
        int         status;
        int         bal0;
        int         bal1;
        int         cycles;
        string      line;
        void'($urandom(79));
        global_reset = 1'b1;
        start_signal = 1'b0;
        load_signal  = 1'b0;
        abort        = 1'b0;
        data         = '0;
        repeat (4) @(posedge clock);
        #1;
        global_reset = 1'b0;
        check_state(state, STARTUP, "state after reset");
        check_number(result_valid, 0, "result_valid after reset");
        start_signal = 1'b1;
        wait_for_state(IDLE, "IDLE after ledger init", cycles);
        start_signal = 1'b0;
        fd = $fopen("wallet_game_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open wallet_game_cases.txt for reading");
            other_errors++;
        end else begin
            line_no = 0;
            while ($fgets(line, fd) > 0) begin
                line_no++;
                if ($sscanf(line, "%d %d %d %h %d %d %d", op, player, amount, key, status,
                            bal0, bal1) == 7) begin
                    if (op == 1) begin
                        run_abort(player, amount);
                    end else begin
                        run_transfer(player, amount, key, outcome_t'(status), bal0, bal1,
                                     line_no);
                    end
                end
            end
            $fclose(fd);
            check_count(transfer_count, ok_count[7:0], "transfer_count at the end");
            check_number(int'(result.balance0) + int'(result.balance1),
                         `WG_INIT_BAL0 + `WG_INIT_BAL1, "sum of balances");
            check_number(valid_pulses, expected_pulses, "result_valid pulse count");
        end
        finish_run();
    end

endmodule

/* wallet_game_cases.txt */
# op player amount key status bal0 bal1 (op 0 transfer, 1 abort in WAIT2; amount decimal, key hex)
# status 0 OK, 1 BAD_KEY, 2 SHORT_FUNDS; bal0 bal1 are the balances after the line
0 0 300 3A 0 700 800
0 1 200 C5 0 900 600
0 0 100 55 1 900 600
0 1 700 C5 2 900 600
1 0 50 3A 0 900 600
0 0 400 3A 0 500 1000
0 1 1000 C5 0 1500 0
0 0 1501 3A 2 1500 0
0 1 1 3A 1 1500 0
0 0 1500 3A 0 0 1500

/* wallet_game.f */
+incdir+.
wallet_game_pkg.sv
command_capture.sv
main_control.sv
ledger.sv
result_reporter.sv
wallet_game_top.sv
tb_wallet_game.sv

/* Bender.yml */
package:
  name: wallet_game

sources:
  - include_dirs:
      - .
    files:
      - wallet_game_pkg.sv
      - command_capture.sv
      - main_control.sv
      - ledger.sv
      - result_reporter.sv
      - wallet_game_top.sv
      - target: test
        files:
          - tb_wallet_game.sv
